/* tank_defs.svh */
// Enemy tank subsystem constants
// Tank count, spawn schedule, respawn delay, FIFO depth and field widths
// shared by the producer, the command FIFO, the consumer and the testbench
`ifndef TANK_DEFS_SVH
`define TANK_DEFS_SVH

// Number of enemy tanks and the width of a tank index
`define TANK_COUNT 4
`define TANK_ID_W 2

// Tick of the first spawn after reset and the gap between first spawns
// Tanks therefore first enter at ticks 4, 16, 28 and 40
`define FIRST_SPAWN 4
`define SPAWN_STAGGER 12

// Ticks from an accepted hit to the spawn command of that tank
`define RESPAWN_DELAY 13

// Number of spawn points along the top edge of the field
`define SPAWN_POINTS 3

// Command slots, two outstanding commands per tank
`define FIFO_DEPTH 8

// Field coordinate width and width of the retire tick stamp
`define POS_W 6
`define TICK_W 13

`endif

/* tank_pkg.sv */
// Enemy tank types
// Command word with its spawn and retire views, per-tank state as seen by
// the playfield, and the table of spawn point coordinates
`include "tank_defs.svh"

package tank_pkg;

	// Kind bit sits at the top of both command views
	typedef enum logic [0:0] {
		SPAWN  = 1'b0,
		RETIRE = 1'b1
	} tank_cmd_kind_e;

	// Spawn view carries the spawn point and its coordinates
	typedef struct packed {
		tank_cmd_kind_e        kind;
		logic [`TANK_ID_W-1:0] id;
		logic [1:0]            pt;
		logic [`POS_W-1:0]     x;
		logic [`POS_W-1:0]     y;
	} tank_spawn_s;

	// Retire view carries the tick of the accepted hit for the score logic
	// The spare bit lines it up with the 17-bit spawn view
	typedef struct packed {
		tank_cmd_kind_e        kind;
		logic [`TANK_ID_W-1:0] id;
		logic                  rsvd;
		logic [`TICK_W-1:0]    tick;
	} tank_retire_s;

	// Kind and id occupy the same bits in both views
	typedef union packed {
		tank_spawn_s  spawn;
		tank_retire_s retire;
	} tank_cmd_u;

	typedef struct packed {
		logic              en;
		logic [`POS_W-1:0] x;
		logic [`POS_W-1:0] y;
	} tank_state_s;

	typedef tank_state_s [`TANK_COUNT-1:0] tank_state_a;

	// Spawn points 0, 1 and 2 at (2,2), (31,2) and (60,2), point 0 in the low slot
	localparam logic [`SPAWN_POINTS-1:0][`POS_W-1:0] SPAWN_X = {6'd60, 6'd31, 6'd2};
	localparam logic [`SPAWN_POINTS-1:0][`POS_W-1:0] SPAWN_Y = {6'd2, 6'd2, 6'd2};

endpackage

/* tank_spawn_ctrl.sv */
// Enemy tank spawn controller
// Schedules the staggered first entry of every tank, accepts hits on live
// tanks, times their respawn and queues SPAWN and RETIRE commands. One
// pending command register feeds the FIFO and holds still under back-pressure
`timescale 1ns/1ps
`include "tank_defs.svh"

module tank_spawn_ctrl
(
	input  logic                   clk_4Hz,
	input  logic                   rst_n,
	input  logic [`TANK_COUNT-1:0] hit,
	input  logic                   full,
	output logic                   push,
	output tank_pkg::tank_cmd_u    push_cmd
);

	// Due events are detected one tick early so the command is on push in the due tick
	localparam int LAST_DUE = `FIRST_SPAWN + (`TANK_COUNT - 1) * `SPAWN_STAGGER - 1;
	localparam int START_W = $clog2(LAST_DUE + 2);
	localparam int CNT_W = $clog2(`RESPAWN_DELAY + 1);

	logic [START_W-1:0]     start_cnt;
	logic [`TICK_W-1:0]     tick_cnt;
	logic [`TICK_W-1:0]     hit_tick [`TANK_COUNT];
	logic [CNT_W-1:0]       resp_cnt [`TANK_COUNT];
	logic [`TANK_COUNT-1:0] live;
	logic [`TANK_COUNT-1:0] spawn_pend;
	logic [`TANK_COUNT-1:0] retire_pend;
	logic [`TANK_COUNT-1:0] spawn_due;
	logic [`TANK_COUNT-1:0] hit_acc;
	logic [`TANK_COUNT-1:0] spawn_req;
	logic [`TANK_COUNT-1:0] retire_req;
	logic [`TANK_COUNT-1:0] req;
	logic [`TANK_COUNT-1:0] grant;
	logic [1:0]             pt_idx;
	logic [`TANK_ID_W-1:0]  sel;
	logic                   load;
	logic                   push_q;
	tank_pkg::tank_cmd_u    cmd_next;
	tank_pkg::tank_cmd_u    cmd_q;

	// A spawn falls due at the tick before its first entry or when the respawn countdown ends
	always_comb
	begin
		for (int i = 0; i < `TANK_COUNT; i++)
		begin
			spawn_due[i] = (start_cnt == START_W'(`FIRST_SPAWN + i * `SPAWN_STAGGER - 1)) ||
				(resp_cnt[i] == CNT_W'(1));
		end
	end

	// Hits on tanks that are not live are dropped here
	assign hit_acc = hit & live;
	assign spawn_req = spawn_due | spawn_pend;
	assign retire_req = hit_acc | retire_pend;
	assign req = spawn_req | retire_req;

	// The register takes a new command when it is empty or its command leaves this tick
	assign load = (|req) && (!push_q || !full);

	// Fixed priority, the lowest tank id wins
	always_comb
	begin
		sel = '0;
		for (int i = `TANK_COUNT - 1; i >= 0; i--)
		begin
			if (req[i])
				sel = `TANK_ID_W'(i);
		end
	end

	assign grant = load ? (`TANK_COUNT'(1) << sel) : '0;

	// Encode the chosen event through the view that matches its kind
	always_comb
	begin
		cmd_next = '0;
		if (retire_req[sel])
		begin
			cmd_next.retire.kind = tank_pkg::RETIRE;
			cmd_next.retire.id = sel;
			// A hit granted in its own tick has no stamp stored yet
			cmd_next.retire.tick = hit_acc[sel] ? tick_cnt : hit_tick[sel];
		end
		else
		begin
			cmd_next.spawn.kind = tank_pkg::SPAWN;
			cmd_next.spawn.id = sel;
			cmd_next.spawn.pt = pt_idx;
			cmd_next.spawn.x = tank_pkg::SPAWN_X[pt_idx];
			cmd_next.spawn.y = tank_pkg::SPAWN_Y[pt_idx];
		end
	end

	always_ff @(posedge clk_4Hz)
	begin
		if (!rst_n)
		begin
			start_cnt <= '0;
			tick_cnt <= '0;
			live <= '0;
			spawn_pend <= '0;
			retire_pend <= '0;
			pt_idx <= '0;
			push_q <= 1'b0;
			for (int i = 0; i < `TANK_COUNT; i++)
				resp_cnt[i] <= '0;
		end
		else
		begin
			tick_cnt <= tick_cnt + 1'b1;
			// The start counter parks one past the last first-spawn tick
			if (start_cnt <= START_W'(LAST_DUE))
				start_cnt <= start_cnt + 1'b1;
			for (int i = 0; i < `TANK_COUNT; i++)
			begin
				if (hit_acc[i])
				begin
					live[i] <= 1'b0;
					resp_cnt[i] <= CNT_W'(`RESPAWN_DELAY - 1);
				end
				else if (resp_cnt[i] != '0)
					resp_cnt[i] <= resp_cnt[i] - 1'b1;
			end
			// Events that lost the pick wait for a later tick
			spawn_pend <= spawn_req & ~grant;
			retire_pend <= retire_req & ~grant;
			if (load)
			begin
				push_q <= 1'b1;
				if (!retire_req[sel])
				begin
					live[sel] <= 1'b1;
					pt_idx <= (pt_idx == 2'(`SPAWN_POINTS - 1)) ? 2'd0 : pt_idx + 1'b1;
				end
			end
			else if (!full)
				push_q <= 1'b0;
		end
	end

	// Command word and hit stamps are payload
	always_ff @(posedge clk_4Hz)
	begin
		if (load)
			cmd_q <= cmd_next;
		for (int i = 0; i < `TANK_COUNT; i++)
		begin
			if (hit_acc[i])
				hit_tick[i] <= tick_cnt;
		end
	end

	assign push = push_q;
	assign push_cmd = cmd_q;

endmodule

/* spawn_fifo.sv */
// Spawn command FIFO
// Circular buffer of tank commands between the spawn controller and the
// tank activator, with the head entry always on its output
`timescale 1ns/1ps
`include "tank_defs.svh"

module spawn_fifo
(
	input  logic                clk_4Hz,
	input  logic                rst_n,
	input  logic                push,
	input  tank_pkg::tank_cmd_u push_cmd,
	input  logic                pop,
	output logic                full,
	output logic                empty,
	output tank_pkg::tank_cmd_u pop_cmd
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

	tank_pkg::tank_cmd_u mem [`FIFO_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic                do_push;
	logic                do_pop;

	// Requests against a full or empty buffer are ignored
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == CNT_W'(`FIFO_DEPTH));
	assign empty = (count == '0);

	// Head entry goes out without a register stage
	assign pop_cmd = mem[rd_ptr];

	always_ff @(posedge clk_4Hz)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// A push and a pop in one tick leave the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk_4Hz)
	begin
		if (do_push)
			mem[wr_ptr] <= push_cmd;
	end

endmodule

/* tank_activator.sv */
// Enemy tank activator
// Pops commands from the spawn FIFO while the game runs and keeps the
// enable flag and position of every tank for the playfield logic
`timescale 1ns/1ps
`include "tank_defs.svh"

module tank_activator
(
	input  logic                  clk_4Hz,
	input  logic                  rst_n,
	input  logic                  freeze,
	input  logic                  empty,
	input  tank_pkg::tank_cmd_u   pop_cmd,
	output logic                  pop,
	output tank_pkg::tank_state_a tanks
);

	logic [`TANK_COUNT-1:0]   en_q;
	logic [`POS_W-1:0]        x_q [`TANK_COUNT];
	logic [`POS_W-1:0]        y_q [`TANK_COUNT];
	tank_pkg::tank_cmd_kind_e kind;

	// A paused game leaves commands queued
	assign pop = !empty && !freeze;

	// The kind bit is common to both views, so either view can supply it
	assign kind = pop_cmd.spawn.kind;

	always_ff @(posedge clk_4Hz)
	begin
		if (!rst_n)
			en_q <= '0;
		else if (pop)
		begin
			case (kind)
				tank_pkg::SPAWN:
					en_q[pop_cmd.spawn.id] <= 1'b1;
				tank_pkg::RETIRE:
					en_q[pop_cmd.retire.id] <= 1'b0;
			endcase
		end
	end

	// A retired tank keeps its last position
	always_ff @(posedge clk_4Hz)
	begin
		if (pop && kind == tank_pkg::SPAWN)
		begin
			x_q[pop_cmd.spawn.id] <= pop_cmd.spawn.x;
			y_q[pop_cmd.spawn.id] <= pop_cmd.spawn.y;
		end
	end

	// Gather the per-tank state into the array the playfield reads
	always_comb
	begin
		for (int i = 0; i < `TANK_COUNT; i++)
		begin
			tanks[i].en = en_q[i];
			tanks[i].x = x_q[i];
			tanks[i].y = y_q[i];
		end
	end

endmodule

/* enemy_tanks_top.sv */
// Enemy tank life cycle top level
// Spawn controller feeds the command FIFO, and the activator drains it
// into the per-tank state read by the playfield
`timescale 1ns/1ps
`include "tank_defs.svh"

module enemy_tanks_top
(
	input  logic                   clk_4Hz,
	input  logic                   rst_n,
	input  logic [`TANK_COUNT-1:0] hit,
	input  logic                   freeze,
	output tank_pkg::tank_state_a  tanks
);

	// Producer side of the FIFO
	logic                push;
	tank_pkg::tank_cmd_u push_cmd;
	logic                full;

	// Consumer side of the FIFO
	logic                pop;
	tank_pkg::tank_cmd_u pop_cmd;
	logic                empty;

	tank_spawn_ctrl ctrl0 (
		.clk_4Hz  (clk_4Hz),
		.rst_n    (rst_n),
		.hit      (hit),
		.full     (full),
		.push     (push),
		.push_cmd (push_cmd)
	);

	spawn_fifo fifo0 (
		.clk_4Hz  (clk_4Hz),
		.rst_n    (rst_n),
		.push     (push),
		.push_cmd (push_cmd),
		.pop      (pop),
		.full     (full),
		.empty    (empty),
		.pop_cmd  (pop_cmd)
	);

	// Freeze only holds back the consumer, the producer keeps queuing
	tank_activator act0 (
		.clk_4Hz  (clk_4Hz),
		.rst_n    (rst_n),
		.freeze   (freeze),
		.empty    (empty),
		.pop_cmd  (pop_cmd),
		.pop      (pop),
		.tanks    (tanks)
	);

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset source
// Makes the 8 ns game tick clock and holds the active-low reset for the
// first three rising edges
`timescale 1ns/1ps

module tb_clk_gen
(
	output logic clk_4Hz,
	output logic rst_n
);

	// Free-running clock, 4 ns high and 4 ns low
	initial
	begin
		clk_4Hz = 1'b0;
		forever
			#4 clk_4Hz = ~clk_4Hz;
	end

	// Reset is released a little after the third rising edge, like any other input
	initial
	begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk_4Hz);
		#1 rst_n = 1'b1;
	end

endmodule

/* enemy_tanks_chk.sv */
// Enemy tank top-level checker
// Concurrent assertions on the FIFO handshake and on the tank enables,
// bound into the top level of the enemy tank subsystem
`timescale 1ns/1ps
`include "tank_defs.svh"

module enemy_tanks_chk
(
	input logic                  clk_4Hz,
	input logic                  rst_n,
	input logic                  push,
	input logic                  full,
	input logic                  pop,
	input logic                  empty,
	input tank_pkg::tank_state_a tanks
);

	logic [`TANK_COUNT-1:0] en_vec;

	// Enable flags gathered into one vector
	always_comb
	begin
		for (int i = 0; i < `TANK_COUNT; i++)
			en_vec[i] = tanks[i].en;
	end

	// The FIFO never sees a command offered while it is full
	a_no_push_full: assert property (@(posedge clk_4Hz) disable iff (!rst_n) !(push && full))
		else $error("push is high while the FIFO is full");

	// The activator never pops an empty FIFO
	a_no_pop_empty: assert property (@(posedge clk_4Hz) disable iff (!rst_n) !(pop && empty))
		else $error("pop is high while the FIFO is empty");

	// A reset cycle leaves every tank disabled in the next cycle
	a_reset_clear: assert property (@(posedge clk_4Hz) !rst_n |=> (en_vec == '0))
		else $error("tank enables are not all low after reset");

	// A tank only enters the field as the result of a popped command
	for (genvar i = 0; i < `TANK_COUNT; i++)
	begin : g_rise
		a_rise_after_pop: assert property (@(posedge clk_4Hz) disable iff (!rst_n)
			$rose(en_vec[i]) |-> $past(pop))
			else $error("tank %0d enable rose without a pop in the cycle before", i);
	end

endmodule

/* tb_enemy_tanks.sv */
// Enemy tank subsystem testbench
// Directed tests for staggered entry, hit and respawn, ignored hits, freeze
// and simultaneous hits, checked against a small model of the tank states
`timescale 1ns/1ps
`include "tank_defs.svh"

module tb_enemy_tanks;

	logic                   clk_4Hz;
	logic                   rst_n;
	logic [`TANK_COUNT-1:0] hit;
	logic                   freeze;
	tank_pkg::tank_state_a  tanks;

	// Model of what the playfield should read, and the next spawn point
	tank_pkg::tank_state_a  model;
	int                     pt_next;
	int                     tick_now;
	int                     seed;
	int                     err_count;
	int                     test_err_base;
	int                     tests_passed;
	int                     tests_failed;

	tb_clk_gen clk0 (
		.clk_4Hz (clk_4Hz),
		.rst_n   (rst_n)
	);

	enemy_tanks_top dut0 (
		.clk_4Hz (clk_4Hz),
		.rst_n   (rst_n),
		.hit     (hit),
		.freeze  (freeze),
		.tanks   (tanks)
	);

	bind enemy_tanks_top enemy_tanks_chk chk0 (
		.clk_4Hz (clk_4Hz),
		.rst_n   (rst_n),
		.push    (push),
		.full    (full),
		.pop     (pop),
		.empty   (empty),
		.tanks   (tanks)
	);

	// Game tick index, 0 in the first cycle after reset release
	always @(posedge clk_4Hz)
	begin
		if (!rst_n)
			tick_now <= 0;
		else
			tick_now <= tick_now + 1;
	end

	// All driving and sampling happens 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_4Hz);
		#1;
	endtask

	function automatic logic [`TANK_COUNT-1:0] en_vec(input tank_pkg::tank_state_a t);
		logic [`TANK_COUNT-1:0] v;
		for (int i = 0; i < `TANK_COUNT; i++)
			v[i] = t[i].en;
		return v;
	endfunction

	// State of a tank standing on spawn point pt
	function automatic tank_pkg::tank_state_s point_state(input int pt);
		tank_pkg::tank_state_s s;
		s.en = 1'b1;
		s.x = tank_pkg::SPAWN_X[pt];
		s.y = tank_pkg::SPAWN_Y[pt];
		return s;
	endfunction

	// Spawn points are handed out round-robin in command order
	task automatic expect_spawn(input int id);
		model[id] = point_state(pt_next);
		pt_next = (pt_next + 1) % `SPAWN_POINTS;
	endtask

	// A retired tank keeps its last position
	task automatic expect_retire(input int id);
		model[id].en = 1'b0;
	endtask

	task automatic check_state(input string name, input tank_pkg::tank_state_s exp,
		input tank_pkg::tank_state_s act);
		if (act !== exp)
		begin
			$display("Error: %s state expected en=%0b x=%0d y=%0d actual en=%0b x=%0d y=%0d",
				name, exp.en, exp.x, exp.y, act.en, act.x, act.y);
			err_count++;
		end
	endtask

	task automatic check_en(input string name, input logic [`TANK_COUNT-1:0] exp,
		input logic [`TANK_COUNT-1:0] act);
		if (act !== exp)
		begin
			$display("Error: %s enables expected %b actual %b", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_tick(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("Error: %s tick expected %0d actual %0d", name, exp, act);
			err_count++;
		end
	endtask

	// Compare one tank and the whole enable vector with the model
	task automatic check_tank(input string name, input int id);
		check_state(name, model[id], tanks[id]);
		check_en(name, en_vec(model), en_vec(tanks));
	endtask

	// Waits until the tank's enable reaches level, and returns the tick it was seen
	task automatic wait_en(input int id, input logic level, input int limit, output int seen);
		int n;
		n = 0;
		while (tanks[id].en !== level && n < limit)
		begin
			next_cycle();
			n++;
		end
		seen = tick_now;
		if (tanks[id].en !== level)
		begin
			$display("Timeout: tank %0d enable never went %s within %0d cycles",
				id, level ? "high" : "low", limit);
			err_count++;
			seen = -1;
		end
	endtask

	task automatic start_test();
		test_err_base = err_count;
	endtask

	task automatic finish_test(input string name);
		if (err_count == test_err_base)
		begin
			tests_passed++;
			$display("Test %s finished with no errors", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s finished with %0d errors", name, err_count - test_err_base);
		end
	endtask

	// Hits land in the tick where tank 0's first spawn falls due, before any tank is live
	// Tank 0 must still enter on time and no other tank may move
	task automatic test_ignored_unspawned();
		string name;
		int n;
		name = "ignored_unspawned";
		start_test();
		n = 0;
		while (tick_now < `FIRST_SPAWN + 2 && n < 10)
		begin
			if (tick_now == `FIRST_SPAWN - 1)
				hit = '1;
			else
				hit = '0;
			check_en(name, '0, en_vec(tanks));
			next_cycle();
			n++;
		end
		hit = '0;
		check_en(name, `TANK_COUNT'(1), en_vec(tanks));
		finish_test(name);
	endtask

	// Each tank enters 2 ticks after its scheduled push, on point i modulo 3
	task automatic test_staggered_entry();
		string name;
		int seen;
		name = "staggered_entry";
		start_test();
		for (int i = 0; i < `TANK_COUNT; i++)
		begin
			wait_en(i, 1'b1, 20, seen);
			check_tick(name, `FIRST_SPAWN + i * `SPAWN_STAGGER + 2, seen);
			expect_spawn(i);
			check_tank(name, i);
		end
		finish_test(name);
	endtask

	task automatic test_hit_respawn();
		string name;
		int h;
		int seen;
		name = "hit_respawn";
		start_test();
		h = tick_now;
		hit = 4'b0100;
		next_cycle();
		hit = '0;
		wait_en(2, 1'b0, 10, seen);
		check_tick(name, h + 3, seen);
		expect_retire(2);
		check_tank(name, 2);
		wait_en(2, 1'b1, 20, seen);
		check_tick(name, h + `RESPAWN_DELAY + 2, seen);
		expect_spawn(2);
		check_tank(name, 2);
		finish_test(name);
	endtask

	// Hits on a retired tank must not restart its respawn countdown
	task automatic test_ignored_retired();
		string name;
		int h;
		int seen;
		name = "ignored_retired";
		start_test();
		h = tick_now;
		hit = 4'b0010;
		next_cycle();
		hit = '0;
		wait_en(1, 1'b0, 10, seen);
		check_tick(name, h + 3, seen);
		expect_retire(1);
		check_tank(name, 1);
		hit = 4'b0010;
		repeat (4) next_cycle();
		hit = '0;
		check_en(name, en_vec(model), en_vec(tanks));
		wait_en(1, 1'b1, 20, seen);
		check_tick(name, h + `RESPAWN_DELAY + 2, seen);
		expect_spawn(1);
		check_tank(name, 1);
		finish_test(name);
	endtask

	// Two retires and two spawns pile up under freeze, then drain one per cycle
	task automatic test_freeze();
		string name;
		int r;
		int seen;
		name = "freeze";
		start_test();
		freeze = 1'b1;
		for (int n = 0; n < 18; n++)
		begin
			if (n == 0)
				hit = 4'b0001;
			else if (n == 2)
				hit = 4'b1000;
			else
				hit = '0;
			check_en(name, en_vec(model), en_vec(tanks));
			next_cycle();
		end
		hit = '0;
		check_state(name, model[0], tanks[0]);
		check_state(name, model[3], tanks[3]);
		freeze = 1'b0;
		r = tick_now;
		wait_en(0, 1'b0, 5, seen);
		check_tick(name, r + 1, seen);
		expect_retire(0);
		check_tank(name, 0);
		next_cycle();
		expect_retire(3);
		check_tank(name, 3);
		next_cycle();
		expect_spawn(0);
		check_tank(name, 0);
		next_cycle();
		expect_spawn(3);
		check_tank(name, 3);
		finish_test(name);
	endtask

	// Same-cycle hits retire and respawn in ascending id order
	task automatic test_simultaneous_hits();
		string name;
		logic [31:0] rnd;
		logic [`TANK_COUNT-1:0] mask;
		int h;
		int k;
		int seen;
		name = "simultaneous_hits";
		start_test();
		rnd = $random(seed);
		mask = rnd[`TANK_COUNT-1:0];
		if (mask == '0)
			mask = 4'b0110;
		h = tick_now;
		hit = mask;
		next_cycle();
		hit = '0;
		k = 0;
		for (int i = 0; i < `TANK_COUNT; i++)
		begin
			if (mask[i])
			begin
				wait_en(i, 1'b0, 10, seen);
				check_tick(name, h + 3 + k, seen);
				expect_retire(i);
				check_tank(name, i);
				k++;
			end
		end
		k = 0;
		for (int i = 0; i < `TANK_COUNT; i++)
		begin
			if (mask[i])
			begin
				wait_en(i, 1'b1, 25, seen);
				check_tick(name, h + `RESPAWN_DELAY + 2 + k, seen);
				expect_spawn(i);
				check_tank(name, i);
				k++;
			end
		end
		finish_test(name);
	endtask

	initial
	begin
		int n;
		hit = '0;
		freeze = 1'b0;
		seed = 32'hbb00;
		model = '0;
		pt_next = 0;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		// Sampled on the edge itself since reset is released 1 ns after one
		n = 0;
		while (rst_n !== 1'b1 && n < 20)
		begin
			@(posedge clk_4Hz);
			n++;
		end
		if (rst_n !== 1'b1)
		begin
			$display("Reset was never released by the clock generator");
			err_count++;
		end
		#1;
		test_ignored_unspawned();
		test_staggered_entry();
		test_hit_respawn();
		test_ignored_retired();
		test_freeze();
		test_simultaneous_hits();
		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && err_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+.
tank_pkg.sv
tank_spawn_ctrl.sv
spawn_fifo.sv
tank_activator.sv
enemy_tanks_top.sv
tb_clk_gen.sv
enemy_tanks_chk.sv
tb_enemy_tanks.sv

/* run.sh */
#!/bin/sh
# Compile the enemy tank testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_enemy_tanks -f list.f -o sim_enemy_tanks

./obj_dir/sim_enemy_tanks 2>&1 | tee sim.log

if grep -qx "Testbench passed" sim.log
then
	exit 0
fi
exit 1
